// File: hdl/rename_pkg.sv
// Shared definitions for the two-wide rename stage
//  - register counts and slot count
//  - logical, physical and flag register name types
//  - incoming request and renamed instruction structs
//  - free-list head structs

package rename_pkg;

	localparam int LOGIC_REGS = 32;
	localparam int PHYS_REGS  = 64;
	localparam int FLAG_REGS  = 16;
	localparam int SLOTS      = 2;

	typedef logic [$clog2(LOGIC_REGS)-1:0] logic_reg_t;
	typedef logic [$clog2(PHYS_REGS)-1:0]  phys_reg_t;
	typedef logic [$clog2(FLAG_REGS)-1:0]  flag_reg_t;
	typedef logic [31:0]                   operand_t;
	typedef logic [4:0]                    cmd_t;

	// Instruction as it arrives from decode
	typedef struct packed {
		logic       valid;
		logic       writeback;
		logic       flags_writeback;
		logic       source0_flags;
		logic_reg_t source0;
		operand_t   source1;
		logic       source1_imm;
		logic_reg_t destination;
		cmd_t       cmd;
	} rename_req_t;

	// Renamed instruction, valid travels separately
	typedef struct packed {
		logic       writeback;
		logic       flags_writeback;
		logic       source0_flags;
		logic       source1_imm;
		cmd_t       cmd;
		logic_reg_t logic_destination;
		phys_reg_t  destination_regname;
		flag_reg_t  flags_regname;
		phys_reg_t  source0;
		operand_t   source1;
	} renamed_op_t;

	// Free-list heads
	typedef struct packed {
		logic      empty;
		phys_reg_t num;
	} gpr_free_t;

	typedef struct packed {
		logic      empty;
		flag_reg_t num;
	} flag_free_t;

endpackage

// File: hdl/gpr_map_table.sv
// General register map table
//  - 32 logical to physical entries, identity after reset
//  - four source lookups, slot 1 sees slot 0's new name
//  - two write ports, slot 1 wins on the same destination
//  - free-list read strobes

`timescale 1ns/10ps

module gpr_map_table import rename_pkg::*; (
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  logic        accept,
	input  rename_req_t prev_0,
	input  rename_req_t prev_1,
	input  gpr_free_t   gpr_free_0,
	input  gpr_free_t   gpr_free_1,
	output logic        gpr_rd_0,
	output logic        gpr_rd_1,
	output phys_reg_t   gpr_src0_0,
	output phys_reg_t   gpr_src1_0,
	output phys_reg_t   gpr_src0_1,
	output phys_reg_t   gpr_src1_1
);

	phys_reg_t  map_q [LOGIC_REGS];
	logic_reg_t src1_idx_0;
	logic_reg_t src1_idx_1;
	logic       hit0_1;
	logic       hit1_1;

	// A slot consumes a head only when it really writes a register
	assign gpr_rd_0 = accept && prev_0.valid && prev_0.writeback;
	assign gpr_rd_1 = accept && prev_1.valid && prev_1.writeback;

	// Register field sits in the low bits of source1
	assign src1_idx_0 = prev_0.source1[$bits(logic_reg_t)-1:0];
	assign src1_idx_1 = prev_1.source1[$bits(logic_reg_t)-1:0];

	// Slot 1 reading what slot 0 writes in the same pair
	assign hit0_1 = gpr_rd_0 && (prev_1.source0 == prev_0.destination);
	assign hit1_1 = gpr_rd_0 && (src1_idx_1 == prev_0.destination);

	// Lookups see the map before this pair's writes
	always_comb begin
		gpr_src0_0 = map_q[prev_0.source0];
		gpr_src1_0 = map_q[src1_idx_0];
		if (hit0_1) begin
			gpr_src0_1 = gpr_free_0.num;
		end
		else begin
			gpr_src0_1 = map_q[prev_1.source0];
		end
		if (hit1_1) begin
			gpr_src1_1 = gpr_free_0.num;
		end
		else begin
			gpr_src1_1 = map_q[src1_idx_1];
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < LOGIC_REGS; i++) begin
				map_q[i] <= phys_reg_t'(i);
			end
		end
		else begin
			if (gpr_rd_0) begin
				map_q[prev_0.destination] <= gpr_free_0.num;
			end
			// Later slot overrides on a shared destination
			if (gpr_rd_1) begin
				map_q[prev_1.destination] <= gpr_free_1.num;
			end
		end
	end

	// Lock in the stage must keep strobes off empty heads
	a_gpr_rd_not_empty: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!(gpr_rd_0 && gpr_free_0.empty) && !(gpr_rd_1 && gpr_free_1.empty)
	) else $error("general free-list head read while empty");

endmodule

// File: hdl/flag_map_table.sv
// Flag register map
//  - current physical flag name, 0 after reset
//  - flag source lookups with slot 0 to slot 1 forwarding
//  - update from the later writing slot
//  - flag free-list read strobes

`timescale 1ns/10ps

module flag_map_table import rename_pkg::*; (
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  logic        accept,
	input  rename_req_t prev_0,
	input  rename_req_t prev_1,
	input  flag_free_t  flag_free_0,
	input  flag_free_t  flag_free_1,
	output logic        flag_rd_0,
	output logic        flag_rd_1,
	output flag_reg_t   flag_src_0,
	output flag_reg_t   flag_src_1
);

	flag_reg_t flag_q;

	assign flag_rd_0 = accept && prev_0.valid && prev_0.flags_writeback;
	assign flag_rd_1 = accept && prev_1.valid && prev_1.flags_writeback;

	// Slot 0 sees the stored name, slot 1 sees slot 0's new one
	assign flag_src_0 = flag_q;
	assign flag_src_1 = flag_rd_0 ? flag_free_0.num : flag_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			flag_q <= '0;
		end
		else if (flag_rd_1) begin
			flag_q <= flag_free_1.num;
		end
		else if (flag_rd_0) begin
			flag_q <= flag_free_0.num;
		end
	end

	a_flag_rd_not_empty: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!(flag_rd_0 && flag_free_0.empty) && !(flag_rd_1 && flag_free_1.empty)
	) else $error("flag free-list head read while empty");

endmodule

// File: hdl/rename_stage.sv
// Rename pipeline stage
//  - lock from free-list heads and downstream, accept for the tables
//  - per-slot operand selection from the map lookups
//  - output registers for both slots, cleared valids on flush

`timescale 1ns/10ps

module rename_stage import rename_pkg::*; (
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  logic        flush,
	input  logic        next_lock,
	input  rename_req_t prev_0,
	input  rename_req_t prev_1,
	input  gpr_free_t   gpr_free_0,
	input  gpr_free_t   gpr_free_1,
	input  flag_free_t  flag_free_0,
	input  flag_free_t  flag_free_1,
	input  phys_reg_t   gpr_src0_0,
	input  phys_reg_t   gpr_src1_0,
	input  phys_reg_t   gpr_src0_1,
	input  phys_reg_t   gpr_src1_1,
	input  flag_reg_t   flag_src_0,
	input  flag_reg_t   flag_src_1,
	output logic        accept,
	output logic        previous_lock,
	output renamed_op_t next_0,
	output renamed_op_t next_1,
	output logic        next_0_valid,
	output logic        next_1_valid
);

	logic        lock;
	rename_req_t req      [SLOTS];
	gpr_free_t   gpr_head [SLOTS];
	flag_free_t  flag_head[SLOTS];
	phys_reg_t   gpr_src0 [SLOTS];
	phys_reg_t   gpr_src1 [SLOTS];
	flag_reg_t   flag_src [SLOTS];
	renamed_op_t op_d     [SLOTS];
	renamed_op_t op_q     [SLOTS];
	logic [SLOTS-1:0] valid_q;

	// Any empty head stalls, even for a slot that would not use it
	assign lock = gpr_free_0.empty || gpr_free_1.empty ||
		flag_free_0.empty || flag_free_1.empty || next_lock;
	assign accept        = !lock && !flush;
	assign previous_lock = lock;

	// Slot arrays so both slots share one piece of selection logic
	assign req[0]       = prev_0;
	assign req[1]       = prev_1;
	assign gpr_head[0]  = gpr_free_0;
	assign gpr_head[1]  = gpr_free_1;
	assign flag_head[0] = flag_free_0;
	assign flag_head[1] = flag_free_1;
	assign gpr_src0[0]  = gpr_src0_0;
	assign gpr_src0[1]  = gpr_src0_1;
	assign gpr_src1[0]  = gpr_src1_0;
	assign gpr_src1[1]  = gpr_src1_1;
	assign flag_src[0]  = flag_src_0;
	assign flag_src[1]  = flag_src_1;

	always_comb begin
		for (int i = 0; i < SLOTS; i++) begin
			op_d[i].writeback           = req[i].writeback;
			op_d[i].flags_writeback     = req[i].flags_writeback;
			op_d[i].source0_flags       = req[i].source0_flags;
			op_d[i].source1_imm         = req[i].source1_imm;
			op_d[i].cmd                 = req[i].cmd;
			op_d[i].logic_destination   = req[i].destination;
			op_d[i].destination_regname = gpr_head[i].num;
			op_d[i].flags_regname       = flag_head[i].num;
			// Flag name is zero-extended into the general name width
			if (req[i].source0_flags) begin
				op_d[i].source0 = phys_reg_t'(flag_src[i]);
			end
			else begin
				op_d[i].source0 = gpr_src0[i];
			end
			if (req[i].source1_imm) begin
				op_d[i].source1 = req[i].source1;
			end
			else begin
				op_d[i].source1 = operand_t'(gpr_src1[i]);
			end
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= '0;
		end
		else if (flush) begin
			valid_q <= '0;
		end
		else if (accept) begin
			valid_q <= {req[1].valid, req[0].valid};
		end
	end

	// Payload only, qualified by valid_q
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			op_q <= op_d;
		end
	end

	assign next_0       = op_q[0];
	assign next_1       = op_q[1];
	assign next_0_valid = valid_q[0] && !lock;
	assign next_1_valid = valid_q[1] && !lock;

	a_no_valid_under_lock: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		lock |-> !(next_0_valid || next_1_valid)
	) else $error("renamed instruction presented while locked");

endmodule

// File: hdl/rename_unit.sv
// Two-wide register rename unit, top level
//  - general map table and flag map table side by side
//  - rename stage combining their lookups

`timescale 1ns/10ps

module rename_unit import rename_pkg::*; (
	input  logic        iCLOCK,
	input  logic        inRESET,
	input  rename_req_t prev_0,
	input  rename_req_t prev_1,
	input  gpr_free_t   gpr_free_0,
	input  gpr_free_t   gpr_free_1,
	input  flag_free_t  flag_free_0,
	input  flag_free_t  flag_free_1,
	input  logic        next_lock,
	input  logic        flush,
	output renamed_op_t next_0,
	output renamed_op_t next_1,
	output logic        next_0_valid,
	output logic        next_1_valid,
	output logic        previous_lock,
	output logic        gpr_rd_0,
	output logic        gpr_rd_1,
	output logic        flag_rd_0,
	output logic        flag_rd_1
);

	logic      accept;
	phys_reg_t gpr_src0_0;
	phys_reg_t gpr_src1_0;
	phys_reg_t gpr_src0_1;
	phys_reg_t gpr_src1_1;
	flag_reg_t flag_src_0;
	flag_reg_t flag_src_1;

	gpr_map_table u_gpr_map (
		.iCLOCK, .inRESET, .accept,
		.prev_0, .prev_1,
		.gpr_free_0, .gpr_free_1,
		.gpr_rd_0, .gpr_rd_1,
		.gpr_src0_0, .gpr_src1_0, .gpr_src0_1, .gpr_src1_1
	);

	flag_map_table u_flag_map (
		.iCLOCK, .inRESET, .accept,
		.prev_0, .prev_1,
		.flag_free_0, .flag_free_1,
		.flag_rd_0, .flag_rd_1,
		.flag_src_0, .flag_src_1
	);

	rename_stage u_stage (
		.iCLOCK, .inRESET, .flush, .next_lock,
		.prev_0, .prev_1,
		.gpr_free_0, .gpr_free_1, .flag_free_0, .flag_free_1,
		.gpr_src0_0, .gpr_src1_0, .gpr_src0_1, .gpr_src1_1,
		.flag_src_0, .flag_src_1,
		.accept, .previous_lock,
		.next_0, .next_1, .next_0_valid, .next_1_valid
	);

endmodule

// File: verif/rename_clock_gen.sv
// Clock and reset for the rename unit testbench
//  - free-running clock, 100 ns period
//  - active-low reset held for the first 4 cycles

`timescale 1ns/10ps

module rename_clock_gen (
	output logic iCLOCK,
	output logic inRESET
);

	localparam int HALF_PERIOD  = 50;
	localparam int RESET_CYCLES = 4;

	initial begin
		iCLOCK = 1'b0;
		forever #HALF_PERIOD iCLOCK = ~iCLOCK;
	end

	// Release just after an edge, away from the sampling point
	initial begin
		inRESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
	end

endmodule

// File: verif/rename_unit_tb.sv
// Testbench for the rename unit
//  - random requests, free heads, stalls and flushes from an LFSR
//  - reference model of both maps and the output stage
//  - per-cycle checks of lock, strobes and renamed instructions
//  - watchdog

`timescale 1ns/10ps

module rename_unit_tb import rename_pkg::*; ();

	localparam int          NUM_TESTS = 2000;
	localparam logic [31:0] SEED      = 32'h3e04_f408;

	logic        iCLOCK, inRESET;
	rename_req_t prev_0, prev_1;
	gpr_free_t   gpr_free_0, gpr_free_1;
	flag_free_t  flag_free_0, flag_free_1;
	logic        next_lock, flush;
	renamed_op_t next_0, next_1;
	logic        next_0_valid, next_1_valid, previous_lock;
	logic        gpr_rd_0, gpr_rd_1, flag_rd_0, flag_rd_1;

	// Model state
	logic [31:0] lfsr;
	phys_reg_t   gmap [LOGIC_REGS];
	flag_reg_t   fmap;
	renamed_op_t exp_q0 [$];
	renamed_op_t exp_q1 [$];
	int          errors;
	int          checks;

	rename_clock_gen u_clk (.iCLOCK, .inRESET);

	rename_unit dut (.*);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		logic        fb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr  = {lfsr[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	function automatic rename_req_t random_req();
		rename_req_t r;
		r.valid           = rand_bits(2) != 0;
		r.writeback       = rand_bits(1);
		r.flags_writeback = rand_bits(1);
		r.source0_flags   = rand_bits(2) == 0;
		r.source0         = logic_reg_t'(rand_bits(5));
		r.source1         = rand_bits(32);
		r.source1_imm     = rand_bits(1);
		r.destination     = logic_reg_t'(rand_bits(5));
		r.cmd             = cmd_t'(rand_bits(5));
		return r;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("error: %s got %h expected %h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic compare_op(input string slot, input renamed_op_t got, input renamed_op_t e);
		check({slot, ".writeback"}, got.writeback, e.writeback);
		check({slot, ".flags_writeback"}, got.flags_writeback, e.flags_writeback);
		check({slot, ".source0_flags"}, got.source0_flags, e.source0_flags);
		check({slot, ".source1_imm"}, got.source1_imm, e.source1_imm);
		check({slot, ".cmd"}, got.cmd, e.cmd);
		check({slot, ".logic_destination"}, got.logic_destination, e.logic_destination);
		check({slot, ".destination_regname"}, got.destination_regname, e.destination_regname);
		check({slot, ".flags_regname"}, got.flags_regname, e.flags_regname);
		check({slot, ".source0"}, got.source0, e.source0);
		check({slot, ".source1"}, got.source1, e.source1);
	endtask

	// Expected instruction from the looked-up names and the sampled heads
	function automatic renamed_op_t expect_op(input rename_req_t r, input phys_reg_t src0,
		input phys_reg_t src1, input flag_reg_t fsrc, input gpr_free_t gh, input flag_free_t fh);
		renamed_op_t op;
		op.writeback           = r.writeback;
		op.flags_writeback     = r.flags_writeback;
		op.source0_flags       = r.source0_flags;
		op.source1_imm         = r.source1_imm;
		op.cmd                 = r.cmd;
		op.logic_destination   = r.destination;
		op.destination_regname = gh.num;
		op.flags_regname       = fh.num;
		op.source0             = r.source0_flags ? phys_reg_t'(fsrc) : src0;
		op.source1             = r.source1_imm ? r.source1 : operand_t'(src1);
		return op;
	endfunction

	task automatic drive_inputs();
		rename_req_t r1;
		prev_0 = random_req();
		r1     = random_req();
		// Bias slot 1 towards slot 0's destination
		if (rand_bits(2) == 0) r1.source0 = prev_0.destination;
		if (rand_bits(2) == 0) r1.source1[$bits(logic_reg_t)-1:0] = prev_0.destination;
		if (rand_bits(3) == 0) r1.destination = prev_0.destination;
		prev_1            = r1;
		gpr_free_0.empty  = rand_bits(3) == 0;
		gpr_free_0.num    = phys_reg_t'(rand_bits(6));
		gpr_free_1.empty  = rand_bits(3) == 0;
		gpr_free_1.num    = phys_reg_t'(rand_bits(6));
		flag_free_0.empty = rand_bits(3) == 0;
		flag_free_0.num   = flag_reg_t'(rand_bits(4));
		flag_free_1.empty = rand_bits(3) == 0;
		flag_free_1.num   = flag_reg_t'(rand_bits(4));
		next_lock         = rand_bits(3) == 0;
		flush             = rand_bits(8) < 6;
	endtask

	// Checks this cycle's outputs, then advances the model over the next edge
	task automatic check_and_step();
		logic       lock, accept, wr0, wr1, fw0, fw1, show0, show1;
		logic_reg_t s1_0, s1_1;
		phys_reg_t  src0_1, src1_1;
		flag_reg_t  fsrc_1;
		lock   = gpr_free_0.empty || gpr_free_1.empty || flag_free_0.empty ||
			flag_free_1.empty || next_lock;
		accept = !lock && !flush;
		wr0    = accept && prev_0.valid && prev_0.writeback;
		wr1    = accept && prev_1.valid && prev_1.writeback;
		fw0    = accept && prev_0.valid && prev_0.flags_writeback;
		fw1    = accept && prev_1.valid && prev_1.flags_writeback;
		show0  = exp_q0.size() > 0 && !lock;
		show1  = exp_q1.size() > 0 && !lock;
		check("previous_lock", previous_lock, lock);
		check("gpr_rd_0", gpr_rd_0, wr0);
		check("gpr_rd_1", gpr_rd_1, wr1);
		check("flag_rd_0", flag_rd_0, fw0);
		check("flag_rd_1", flag_rd_1, fw1);
		check("next_0_valid", next_0_valid, show0);
		check("next_1_valid", next_1_valid, show1);
		if (show0) compare_op("next_0", next_0, exp_q0.pop_front());
		if (show1) compare_op("next_1", next_1, exp_q1.pop_front());
		if (flush) begin
			exp_q0.delete();
			exp_q1.delete();
		end
		else if (accept) begin
			s1_0   = prev_0.source1[$bits(logic_reg_t)-1:0];
			s1_1   = prev_1.source1[$bits(logic_reg_t)-1:0];
			src0_1 = (wr0 && prev_1.source0 == prev_0.destination) ?
				gpr_free_0.num : gmap[prev_1.source0];
			src1_1 = (wr0 && s1_1 == prev_0.destination) ? gpr_free_0.num : gmap[s1_1];
			fsrc_1 = fw0 ? flag_free_0.num : fmap;
			if (prev_0.valid) exp_q0.push_back(expect_op(prev_0, gmap[prev_0.source0],
				gmap[s1_0], fmap, gpr_free_0, flag_free_0));
			if (prev_1.valid) exp_q1.push_back(expect_op(prev_1, src0_1, src1_1, fsrc_1,
				gpr_free_1, flag_free_1));
			// Slot 1 written last so it wins a shared destination
			if (wr0) gmap[prev_0.destination] = gpr_free_0.num;
			if (wr1) gmap[prev_1.destination] = gpr_free_1.num;
			if (fw0) fmap = flag_free_0.num;
			if (fw1) fmap = flag_free_1.num;
		end
	endtask

	initial begin
		lfsr        = SEED;
		errors      = 0;
		checks      = 0;
		fmap        = '0;
		prev_0      = '0;
		prev_1      = '0;
		gpr_free_0  = '0;
		gpr_free_1  = '0;
		flag_free_0 = '0;
		flag_free_1 = '0;
		next_lock   = 1'b0;
		flush       = 1'b0;
		for (int i = 0; i < LOGIC_REGS; i++) gmap[i] = phys_reg_t'(i);
		wait (inRESET === 1'b1);
		for (int t = 0; t < NUM_TESTS; t++) begin
			@(posedge iCLOCK);
			#1;
			drive_inputs();
			@(negedge iCLOCK);
			check_and_step();
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end
		else begin
			$display("Something failed");
		end
		$finish;
	end

	// Three times the nominal run length
	initial begin
		#(NUM_TESTS * 300);
		$display("timeout: the test loop did not complete in time");
		$display("Something failed");
		$finish;
	end

endmodule

// File: rename_unit.f
hdl/rename_pkg.sv
hdl/gpr_map_table.sv
hdl/flag_map_table.sv
hdl/rename_stage.sv
hdl/rename_unit.sv
verif/rename_clock_gen.sv
verif/rename_unit_tb.sv
